/* Bender.yml */
package:
  name: div_unit

sources:
  - target: rtl
    files:
      - rtl/div_arith_pkg.sv
      - rtl/div_flow_pkg.sv
      - rtl/credit_fifo.sv
      - rtl/div_core.sv
      - rtl/div_seq.sv
      - rtl/div_unit_top.sv

  - target: test
    files:
      - dv/div_tb_assert.sv
      - dv/div_tb.sv

/* dv/div_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module div_tb;

    localparam int n_rand = 24;    // back-to-back random rows
    localparam int n_hold = 12;    // rows sent while resp credits are held
    localparam int tmo    = 4000;  // cycles allowed per wait

    typedef struct packed {
        logic [31:0] dividend;
        logic [31:0] divisor;
        logic        sgn;
        logic [31:0] quot;  // expected
        logic [31:0] rem;   // expected
    } row_t;

    logic                     clk;
    logic                     rst;
    logic                     req_valid;
    div_arith_pkg::div_req_t  req_data;
    logic                     req_credit;
    logic                     resp_valid;
    div_arith_pkg::div_resp_t resp_data;
    logic                     resp_credit;

    row_t                     rows[$];
    div_arith_pkg::div_req_t  send_q[$];  // waiting for a request credit
    div_arith_pkg::div_resp_t exp_q[$];   // request order

    int drv_credits;
    int pend_credits;  // credits owed back to the response queue
    int n_resp;
    int n_req_cred;
    int cyc;
    int errors;
    int other_errors;
    bit hold;          // consumer withholds resp_credit
    bit timed_out;     // a wait ran out, later waits are skipped

    div_unit_top div_unit_top_inst (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req_data    (req_data),
        .req_credit  (req_credit),
        .resp_valid  (resp_valid),
        .resp_data   (resp_data),
        .resp_credit (resp_credit)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // truncating division, remainder follows the dividend, /0 gives all ones
    function automatic logic [63:0] model_div(input logic [31:0] a, input logic [31:0] b,
                                              input logic s);
        longint sa;
        longint sb;
        longint q;
        longint r;
        if (b == 32'h0)
            return {32'hffff_ffff, a};
        sa = s ? longint'($signed(a)) : longint'({32'h0, a});  // 64 bits, min/-1 fits
        sb = s ? longint'($signed(b)) : longint'({32'h0, b});
        q = sa / sb;
        r = sa % sb;
        return {q[31:0], r[31:0]};
    endfunction

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s got %08h expected %08h", $time, what, got, exp);
        end
    endtask

    task automatic end_run;
        $display("errors: %0d value mismatches, %0d other failures", errors, other_errors);
        if (errors == 0 && other_errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    endtask

    task automatic add_row(input logic [31:0] a, input logic [31:0] b, input logic s,
                           input logic [31:0] q, input logic [31:0] r);
        rows.push_back('{a, b, s, q, r});
    endtask

    task automatic add_random_row;
        logic [31:0] a;
        logic [31:0] b;
        logic        s;
        logic [63:0] qr;
        a = $urandom;
        s = $urandom_range(0, 1);
        case ($urandom_range(0, 3))
            0:       b = $urandom;
            1:       b = $urandom_range(1, 255);
            2:       b = 32'h0 - $urandom_range(1, 255);  // negative if signed
            default: b = ($urandom_range(0, 7) == 0) ? 32'h0 : a >> $urandom_range(1, 31);
        endcase
        qr = model_div(a, b, s);
        add_row(a, b, s, qr[63:32], qr[31:0]);
    endtask

    task automatic send_row(input row_t r);
        send_q.push_back('{r.dividend, r.divisor, r.sgn});
        exp_q.push_back('{r.quot, r.rem});
    endtask

    task automatic wait_resp_count(input int target, input string what);
        int i;
        i = 0;
        while (!timed_out && n_resp < target && i < tmo) begin
            @(posedge clk);
            i++;
        end
        if (!timed_out && n_resp < target) begin
            other_errors++;
            timed_out = 1'b1;
            $display("timeout at %0t ns waiting for %s, got %0d of %0d responses",
                     $time, what, n_resp, target);
        end
    endtask

    task automatic wait_credit_drain;
        int i;
        i = 0;
        while (!timed_out && pend_credits != 0 && i < tmo) begin
            @(posedge clk);
            i++;
        end
        if (!timed_out && pend_credits != 0) begin
            other_errors++;
            timed_out = 1'b1;
            $display("timeout at %0t ns waiting for resp_credit returns to finish", $time);
        end
    endtask

    // monitor, driver and consumer share one falling edge
    always @(negedge clk) begin
        div_arith_pkg::div_resp_t exp;
        cyc++;
        if (rst) begin
            req_valid    <= 1'b0;
            resp_credit  <= 1'b0;
            drv_credits  = div_flow_pkg::req_depth;
            pend_credits = 0;
        end else begin
            if (req_credit) begin
                drv_credits++;
                n_req_cred++;
            end
            if (resp_valid) begin
                if (exp_q.size() == 0) begin
                    other_errors++;
                    $display("response at %0t ns with no request outstanding", $time);
                end else begin
                    exp = exp_q.pop_front();
                    check_equal(resp_data.quot, exp.quot, $sformatf("resp %0d quot", n_resp));
                    check_equal(resp_data.rem, exp.rem, $sformatf("resp %0d rem", n_resp));
                end
                n_resp++;
                pend_credits++;
            end
            if (send_q.size() != 0 && drv_credits > 0) begin  // spend a credit per valid
                req_data  <= send_q.pop_front();
                req_valid <= 1'b1;
                drv_credits--;
            end else begin
                req_valid <= 1'b0;
            end
            // credit return skips every third cycle
            if (!hold && pend_credits > 0 && (cyc % 3) != 0) begin
                resp_credit <= 1'b1;
                pend_credits--;
            end else begin
                resp_credit <= 1'b0;
            end
        end
    end

    initial begin
        int i;
        int base;
        rst          = 1'b1;
        req_valid    = 1'b0;
        req_data     = '0;
        resp_credit  = 1'b0;
        hold         = 1'b0;
        timed_out    = 1'b0;
        n_resp       = 0;
        n_req_cred   = 0;
        cyc          = 0;
        errors       = 0;
        other_errors = 0;
        void'($urandom(88));

        add_row(32'd100, 32'd7, 1'b0, 32'd14, 32'd2);                // unsigned
        add_row(32'd5, 32'd9, 1'b0, 32'd0, 32'd5);                    // dividend < divisor
        add_row(32'hdeadbeef, 32'd1, 1'b0, 32'hdeadbeef, 32'd0);      // divide by one
        add_row(32'hffffffff, 32'h10, 1'b0, 32'h0fffffff, 32'hf);
        add_row(32'h80000000, 32'd3, 1'b0, 32'h2aaaaaaa, 32'd2);
        add_row(32'hffffff9c, 32'd7, 1'b0, 32'h24924916, 32'd2);      // big unsigned
        add_row(32'd100, 32'd7, 1'b1, 32'd14, 32'd2);                 // + / +
        add_row(32'hffffff9c, 32'd7, 1'b1, 32'hfffffff2, 32'hfffffffe);  // - / +
        add_row(32'd100, 32'hfffffff9, 1'b1, 32'hfffffff2, 32'd2);       // + / -
        add_row(32'hffffff9c, 32'hfffffff9, 1'b1, 32'd14, 32'hfffffffe); // - / -
        add_row(32'd7, 32'hffffff9c, 1'b1, 32'd0, 32'd7);
        add_row(32'h80000000, 32'hffffffff, 1'b1, 32'h80000000, 32'd0);  // overflow case
        add_row(32'h80000000, 32'd2, 1'b1, 32'hc0000000, 32'd0);
        add_row(32'h12345678, 32'd0, 1'b0, 32'hffffffff, 32'h12345678);  // /0 unsigned
        add_row(32'hffffff9c, 32'd0, 1'b1, 32'hffffffff, 32'hffffff9c);  // /0 signed
        for (i = 0; i < n_rand + n_hold; i++)
            add_random_row();

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst <= 1'b0;

        // full-credit run over directed and random rows
        @(posedge clk);
        for (i = 0; i < rows.size() - n_hold; i++)
            send_row(rows[i]);
        wait_resp_count(rows.size() - n_hold, "directed and random responses");
        wait_credit_drain();

        // back-pressure run
        hold = 1'b1;
        base = n_resp;
        for (i = rows.size() - n_hold; i < rows.size(); i++)
            send_row(rows[i]);
        wait_resp_count(base + div_flow_pkg::out_credits_init, "responses under held credits");
        for (i = 0; i < 300; i++)
            @(posedge clk);  // no extra response may show up here
        check_equal(n_resp - base, div_flow_pkg::out_credits_init, "responses while held");
        // both queues full, one result parked in the sequencer
        check_equal(send_q.size(), n_hold - div_flow_pkg::out_credits_init
                    - div_flow_pkg::resp_depth - div_flow_pkg::req_depth - 1,
                    "requests left unsent under back-pressure");
        hold = 1'b0;
        wait_resp_count(base + n_hold, "responses after credit release");

        check_equal(n_req_cred, n_resp, "req_credit pulses vs responses");
        check_equal(exp_q.size(), 0, "responses still outstanding");
        end_run();
    end

endmodule

`default_nettype wire

/* dv/div_tb_assert.sv */
`timescale 1ns/10ps
`default_nettype none

module div_tb_assert (
    input logic clk,
    input logic rst,
    input logic req_credit,
    input logic resp_valid,
    input logic resp_credit,
    input logic core_start,
    input logic core_done
);

    int   resp_cred;  // outside credits as seen by the response queue
    logic busy;       // division in the core

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_cred <= div_flow_pkg::out_credits_init;
            busy      <= 1'b0;
        end else begin
            resp_cred <= resp_cred + int'(resp_credit) - int'(resp_valid);
            if (core_start)
                busy <= 1'b1;
            else if (core_done)
                busy <= 1'b0;
        end
    end

    a_resp_credit: assert property (@(posedge clk) disable iff (rst)
        resp_valid |-> resp_cred > 0)
        else $error("resp_valid with no response credit");

    a_start_idle: assert property (@(posedge clk) disable iff (rst)
        core_start |-> !busy)
        else $error("core_start during a division");

    // one load cycle plus 32 iterations
    a_done_timing: assert property (@(posedge clk) disable iff (rst)
        core_start |=> !core_done [*32] ##1 core_done)
        else $error("core_done not 33 cycles after core_start");

    a_reset_quiet: assert property (@(posedge clk)
        rst |=> !resp_valid && !req_credit && !core_start && !core_done)
        else $error("valid or credit output high after reset");

endmodule

bind div_unit_top div_tb_assert div_tb_assert_inst (.*);

`default_nettype wire

/* rtl/credit_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module credit_fifo #(
    parameter type payload_t    = logic,
    parameter int  depth        = 4,
    parameter int  init_credits = 1
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_credit,     // one pulse per freed slot
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_credit     // receiver freed a slot
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t mem [depth];  // storage

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;  // occupancy
    logic [div_flow_pkg::cred_w-1:0] credits;  // credits toward the receiver

    logic push;
    logic pop;

    // wrap explicitly so any depth works
    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
        logic [ptr_w-1:0] nxt;
        if (p == ptr_w'(depth - 1))
            nxt = '0;
        else
            nxt = p + ptr_w'(1);
        return nxt;
    endfunction

    assign push = in_valid;  // sender only pushes with a credit, so room exists

    // emit while holding an entry and a credit
    assign pop = (count != '0) && (credits != '0);

    assign out_valid = pop;
    assign out_data  = mem[rd_ptr];  // head entry

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= in_data;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            credits   <= div_flow_pkg::cred_w'(init_credits);
            in_credit <= 1'b0;
        end else begin
            if (push)
                wr_ptr <= ptr_inc(wr_ptr);
            if (pop)
                rd_ptr <= ptr_inc(rd_ptr);  // entry leaves at once

            case ({push, pop})
                2'b10:   count <= count + cnt_w'(1);
                2'b01:   count <= count - cnt_w'(1);
                default: count <= count;  // both or neither
            endcase

            // spend on pop, earn on returned credit
            case ({out_credit, pop})
                2'b10:   credits <= credits + div_flow_pkg::cred_w'(1);
                2'b01:   credits <= credits - div_flow_pkg::cred_w'(1);
                default: credits <= credits;
            endcase

            in_credit <= pop;  // freed slot goes back one cycle later
        end
    end

endmodule

`default_nettype wire

/* rtl/div_arith_pkg.sv */
`default_nettype none

package div_arith_pkg;

    // operand and result width
    localparam int data_w = 32;

    // one quotient bit per iteration
    localparam int iter_n = data_w;

    // loop counter width, holds iter_n - 1
    localparam int iter_w = 6;

    // request payload, 65 bits
    typedef struct packed {
        logic [data_w-1:0] dividend;
        logic [data_w-1:0] divisor;
        logic              is_signed;  // 1: two's complement operands
    } div_req_t;

    // response payload, 64 bits
    typedef struct packed {
        logic [data_w-1:0] quot;
        logic [data_w-1:0] rem;
    } div_resp_t;

endpackage

`default_nettype wire

/* rtl/div_core.sv */
`timescale 1ns/10ps
`default_nettype none

module div_core (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           start,     // only honored while idle
    input  logic [div_arith_pkg::data_w-1:0] dividend,
    input  logic [div_arith_pkg::data_w-1:0] divisor,
    output logic                           done,      // one cycle pulse
    output logic [div_arith_pkg::data_w-1:0] quot,
    output logic [div_arith_pkg::data_w-1:0] rem
);

    localparam int dw = div_arith_pkg::data_w;
    localparam int iw = div_arith_pkg::iter_w;

    typedef enum logic [1:0] {
        st_idle,
        st_iter,
        st_finish
    } state_t;

    state_t state;

    logic [iw-1:0] iter_cnt;   // counts down to zero
    logic [dw-1:0] divisor_q;
    logic [dw-1:0] quot_q;     // dividend shifts out, quotient shifts in
    logic [dw-1:0] rem_q;      // partial remainder

    logic [dw:0]   shifted;    // remainder with next dividend bit, can exceed dw bits
    logic [dw+1:0] diff;       // trial subtraction, top bit is the sign
    logic          diff_neg;

    // shift the top quotient bit into the remainder
    assign shifted = {rem_q, quot_q[dw-1]};

    assign diff     = {1'b0, shifted} - {2'b00, divisor_q};
    assign diff_neg = diff[dw+1];

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= st_idle;
            iter_cnt <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state    <= st_iter;
                        iter_cnt <= iw'(div_arith_pkg::iter_n - 1);
                    end
                end
                st_iter: begin
                    if (iter_cnt == '0)
                        state <= st_finish;  // last bit done this cycle
                    else
                        iter_cnt <= iter_cnt - iw'(1);
                end
                st_finish: state <= st_idle;  // single done cycle
                default:   state <= st_idle;
            endcase
        end
    end

    // datapath registers
    always_ff @(posedge clk) begin
        if (state == st_idle && start) begin
            divisor_q <= divisor;
            quot_q    <= dividend;  // dividend preloads the quotient register
            rem_q     <= '0;
        end else if (state == st_iter) begin
            if (!diff_neg) begin
                rem_q  <= diff[dw-1:0];  // difference fits, keep it
                quot_q <= {quot_q[dw-2:0], 1'b1};
            end else begin
                rem_q  <= shifted[dw-1:0];  // restore, shifted < divisor here
                quot_q <= {quot_q[dw-2:0], 1'b0};
            end
        end
    end

    assign done = (state == st_finish);
    assign quot = quot_q;
    assign rem  = rem_q;

endmodule

`default_nettype wire

/* rtl/div_flow_pkg.sv */
`default_nettype none

package div_flow_pkg;

    // queue depths
    localparam int req_depth  = 4;
    localparam int resp_depth = 4;

    // width of every credit counter
    localparam int cred_w = 3;

    // sequencer takes one request at a time
    localparam int seq_credits = 1;

    // credits granted by the consumer after reset
    localparam int out_credits_init = 2;

endpackage

`default_nettype wire

/* rtl/div_seq.sv */
`timescale 1ns/10ps
`default_nettype none

module div_seq (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             seq_valid,
    input  div_arith_pkg::div_req_t          seq_data,
    output logic                             seq_credit,    // request finished
    output logic                             core_start,
    output logic [div_arith_pkg::data_w-1:0] core_dividend,
    output logic [div_arith_pkg::data_w-1:0] core_divisor,
    input  logic                             core_done,
    input  logic [div_arith_pkg::data_w-1:0] core_quot,
    input  logic [div_arith_pkg::data_w-1:0] core_rem,
    output logic                             rq_valid,
    output div_arith_pkg::div_resp_t         rq_data,
    input  logic                             rq_credit
);

    localparam int dw = div_arith_pkg::data_w;
    localparam int cw = div_flow_pkg::cred_w;

    typedef enum logic [1:0] {
        st_idle,
        st_start,  // core_start high
        st_busy,   // waiting for core_done
        st_resp    // result ready, waiting for a credit
    } state_t;

    state_t state;

    logic [cw-1:0] credits;  // free slots in the response queue

    logic          a_neg;     // dividend negative
    logic          b_neg;     // divisor negative
    logic [dw-1:0] a_mag;
    logic [dw-1:0] b_mag;
    logic          div_zero;

    logic          neg_quot_q;  // signs differ
    logic          neg_rem_q;   // remainder follows the dividend
    logic          fire;

    div_arith_pkg::div_resp_t res_q;

    // signs only count for signed requests
    assign a_neg = seq_data.is_signed & seq_data.dividend[dw-1];
    assign b_neg = seq_data.is_signed & seq_data.divisor[dw-1];
    assign a_mag = a_neg ? -seq_data.dividend : seq_data.dividend;
    assign b_mag = b_neg ? -seq_data.divisor : seq_data.divisor;  // min int stays 2^31

    assign div_zero = (seq_data.divisor == '0);

    assign core_start = (state == st_start);

    assign fire       = (state == st_resp) && (credits != '0);
    assign rq_valid   = fire;
    assign rq_data    = res_q;
    assign seq_credit = fire;  // request slot freed with the push

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= st_idle;
            credits <= cw'(div_flow_pkg::resp_depth);
        end else begin
            case (state)
                st_idle: begin
                    if (seq_valid)
                        state <= div_zero ? st_resp : st_start;  // bypass the core on /0
                end
                st_start: state <= st_busy;
                st_busy: begin
                    if (core_done)
                        state <= st_resp;
                end
                st_resp: begin
                    if (fire)
                        state <= st_idle;
                end
                default: state <= st_idle;
            endcase

            case ({rq_credit, fire})
                2'b10:   credits <= credits + cw'(1);
                2'b01:   credits <= credits - cw'(1);
                default: credits <= credits;
            endcase
        end
    end

    // operands and result
    always_ff @(posedge clk) begin
        if (state == st_idle && seq_valid) begin
            core_dividend <= a_mag;
            core_divisor  <= b_mag;
            neg_quot_q    <= a_neg ^ b_neg;
            neg_rem_q     <= a_neg;
            if (div_zero) begin
                res_q.quot <= '1;                 // all ones
                res_q.rem  <= seq_data.dividend;  // untouched dividend
            end
        end
        if (state == st_busy && core_done) begin
            res_q.quot <= neg_quot_q ? -core_quot : core_quot;
            res_q.rem  <= neg_rem_q ? -core_rem : core_rem;
        end
    end

endmodule

`default_nettype wire

/* rtl/div_unit_top.sv */
`timescale 1ns/10ps
`default_nettype none

module div_unit_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req_valid,
    input  div_arith_pkg::div_req_t  req_data,
    output logic                     req_credit,
    output logic                     resp_valid,
    output div_arith_pkg::div_resp_t resp_data,
    input  logic                     resp_credit
);

    // request queue to sequencer
    logic                    seq_valid;
    div_arith_pkg::div_req_t seq_data;
    logic                    seq_credit;

    // sequencer to core
    logic                             core_start;
    logic [div_arith_pkg::data_w-1:0] core_dividend;
    logic [div_arith_pkg::data_w-1:0] core_divisor;
    logic                             core_done;
    logic [div_arith_pkg::data_w-1:0] core_quot;
    logic [div_arith_pkg::data_w-1:0] core_rem;

    // sequencer to response queue
    logic                     rq_valid;
    div_arith_pkg::div_resp_t rq_data;
    logic                     rq_credit;

    credit_fifo #(
        .payload_t    (div_arith_pkg::div_req_t),
        .depth        (div_flow_pkg::req_depth),
        .init_credits (div_flow_pkg::seq_credits)
    ) req_fifo (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (req_valid),
        .in_data    (req_data),
        .in_credit  (req_credit),
        .out_valid  (seq_valid),
        .out_data   (seq_data),
        .out_credit (seq_credit)
    );

    div_seq div_seq_inst (
        .clk           (clk),
        .rst           (rst),
        .seq_valid     (seq_valid),
        .seq_data      (seq_data),
        .seq_credit    (seq_credit),
        .core_start    (core_start),
        .core_dividend (core_dividend),
        .core_divisor  (core_divisor),
        .core_done     (core_done),
        .core_quot     (core_quot),
        .core_rem      (core_rem),
        .rq_valid      (rq_valid),
        .rq_data       (rq_data),
        .rq_credit     (rq_credit)
    );

    div_core div_core_inst (
        .clk      (clk),
        .rst      (rst),
        .start    (core_start),
        .dividend (core_dividend),
        .divisor  (core_divisor),
        .done     (core_done),
        .quot     (core_quot),
        .rem      (core_rem)
    );

    credit_fifo #(
        .payload_t    (div_arith_pkg::div_resp_t),
        .depth        (div_flow_pkg::resp_depth),
        .init_credits (div_flow_pkg::out_credits_init)
    ) resp_fifo (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (rq_valid),
        .in_data    (rq_data),
        .in_credit  (rq_credit),
        .out_valid  (resp_valid),
        .out_data   (resp_data),
        .out_credit (resp_credit)
    );

endmodule

`default_nettype wire

/* sources.f */
rtl/div_arith_pkg.sv
rtl/div_flow_pkg.sv
rtl/credit_fifo.sv
rtl/div_core.sv
rtl/div_seq.sv
rtl/div_unit_top.sv
dv/div_tb_assert.sv
dv/div_tb.sv
